// File: fetch_buffer_defs.svh
`ifndef FETCH_BUFFER_DEFS_SVH
`define FETCH_BUFFER_DEFS_SVH

// =====================================
// fetch buffer geometry
// =====================================

// one cache line as returned by the read channel
`define FB_LINE_BITS 128

// line entries held in the FIFO
// must stay a power of two for the wrap-bit pointers
`define FB_DEPTH 4

// =====================================
// boot state
// =====================================

// first instruction address after reset
`define FB_RESET_PC 32'h8000_0000

`endif

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_buffer_defs.svh"

package fetch_pkg;

  // =====================================
  // fetch address
  // =====================================

  // line number of a 16-byte cache line
  typedef logic [27:0] line_tag_t;

  // field view of a fetch address
  typedef struct packed {
    line_tag_t  tag;
    logic [1:0] word;
    logic [1:0] byte_off;
  } fetch_fields_t;

  // same word seen raw or split into line fields
  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_t f;
  } fetch_addr_u;

  // =====================================
  // cache read channels
  // =====================================

  // address channel, addr is always line aligned
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } ar_req_t;

  // read data channel, one full line per beat
  typedef struct packed {
    logic                     valid;
    logic [`FB_LINE_BITS-1:0] data;
  } r_rsp_t;

  // commands from the controller to the FIFO and the tag tracker
  typedef struct packed {
    logic push;
    logic pop;
    logic flush;
  } fifo_ctrl_t;

endpackage

`default_nettype wire

// File: fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl
  import fetch_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        jmp_flush_i,
  input  wire        ar_ready_i,
  input  wire        r_valid_i,
  input  wire        head_hit_i,
  input  wire        pc_miss_i,
  input  wire        full_i,
  input  wire        empty_i,
  output logic       ar_valid_o,
  output logic       r_ready_o,
  output fifo_ctrl_t fifo_ctrl_o,
  output logic       resp_live_o
);

  typedef enum logic {
    S_IDLE = 1'b0,
    S_WAIT = 1'b1
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   run_q;
  logic   stale_q;
  logic   ar_fire;
  logic   r_fire;

  // =====================================
  // read channel handshakes
  // =====================================

  // held off for one cycle after reset via run_q
  assign ar_valid_o = run_q && (state_q == S_IDLE) && !full_i && !jmp_flush_i;

  // ready comes straight from the state flop
  assign r_ready_o = (state_q == S_WAIT);

  assign ar_fire = ar_valid_o && ar_ready_i;
  assign r_fire  = r_valid_i && r_ready_o;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (ar_fire) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (r_fire) begin
          state_d = S_IDLE;
        end
      end
      default: begin
        state_d = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= S_IDLE;
      run_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      run_q   <= 1'b1;
    end
  end

  // =====================================
  // stale response tracking
  // =====================================

  // a flush while a line is in flight orphans that line
  // an address transfer never coincides with a flush, the request is withdrawn
  always_ff @(posedge clk) begin
    if (rst_n) begin
      stale_q <= 1'b0;
    end else if (r_fire) begin
      stale_q <= 1'b0;
    end else if (jmp_flush_i && (state_q == S_WAIT)) begin
      stale_q <= 1'b1;
    end
  end

  // =====================================
  // FIFO commands
  // =====================================

  // a response in the flush cycle is dropped as well
  assign fifo_ctrl_o.push  = r_fire && !stale_q && !jmp_flush_i;
  assign fifo_ctrl_o.pop   = !empty_i && pc_miss_i && !jmp_flush_i;
  assign fifo_ctrl_o.flush = jmp_flush_i;

  // response belongs to the current stream and to the pc line
  assign resp_live_o = !stale_q && !jmp_flush_i && head_hit_i;

  a_no_ar_in_wait: assert property (@(posedge clk) disable iff (rst_n)
    (state_q == S_WAIT) |-> !ar_valid_o)
    else $error("address request raised while a read is outstanding");

  // occupancy plus the single in-flight line never exceeds the depth
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_n)
    fifo_ctrl_o.push |-> !full_i)
    else $error("line pushed into a full FIFO");

endmodule

`default_nettype wire

// File: line_tag_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_buffer_defs.svh"

module line_tag_tracker
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  fetch_addr_u pc_i,
  input  wire         ar_fire_i,
  input  fifo_ctrl_t  fifo_ctrl_i,
  output logic [31:0] ar_addr_o,
  output logic        head_hit_o,
  output logic        pc_miss_o,
  output line_tag_t   head_tag_o
);

  localparam fetch_addr_u RESET_ADDR = `FB_RESET_PC;

  line_tag_t   head_tag_q;
  line_tag_t   req_tag_q;
  fetch_addr_u req_addr;

  // =====================================
  // tag registers
  // =====================================

  // head tag follows pops, request tag follows address transfers
  always_ff @(posedge clk) begin
    if (rst_n) begin
      head_tag_q <= RESET_ADDR.f.tag;
      req_tag_q  <= RESET_ADDR.f.tag;
    end else if (fifo_ctrl_i.flush) begin
      head_tag_q <= pc_i.f.tag;
      req_tag_q  <= pc_i.f.tag;
    end else begin
      if (fifo_ctrl_i.pop) begin
        head_tag_q <= head_tag_q + line_tag_t'(1);
      end
      if (ar_fire_i) begin
        req_tag_q <= req_tag_q + line_tag_t'(1);
      end
    end
  end

  // =====================================
  // pc compare and request address
  // =====================================

  assign head_hit_o = (head_tag_q == pc_i.f.tag);
  assign pc_miss_o  = !head_hit_o;
  assign head_tag_o = head_tag_q;

  // line aligned, low fields forced to zero
  always_comb begin
    req_addr.f.tag      = req_tag_q;
    req_addr.f.word     = 2'd0;
    req_addr.f.byte_off = 2'd0;
  end

  assign ar_addr_o = req_addr.raw;

  // lines requested ahead of the head are bounded by the FIFO depth
  a_req_window: assert property (@(posedge clk) disable iff (rst_n)
    line_tag_t'(req_tag_q - head_tag_q) <= line_tag_t'(`FB_DEPTH))
    else $error("request tag ran more than a FIFO ahead of the head");

endmodule

`default_nettype wire

// File: line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_buffer_defs.svh"

module line_fifo
  import fetch_pkg::*;
(
  input  wire                     clk,
  input  wire                     rst_n,
  input  fifo_ctrl_t              fifo_ctrl_i,
  input  wire [`FB_LINE_BITS-1:0] wdata_i,
  input  wire                     resp_live_i,
  input  wire                     r_fire_i,
  input  wire                     resp_tag_match_i,
  input  wire                     head_hit_i,
  input  wire [1:0]               word_idx_i,
  output logic                    full_o,
  output logic                    empty_o,
  output logic                    inst_valid_o,
  output logic [31:0]             inst_o
);

  localparam int PTR_W     = $clog2(`FB_DEPTH);
  localparam int WORD_BITS = 32;

  logic [`FB_LINE_BITS-1:0] mem [`FB_DEPTH];
  logic [PTR_W:0]           wr_ptr_q;
  logic [PTR_W:0]           rd_ptr_q;
  logic [`FB_LINE_BITS-1:0] src_line;
  logic                     bypass;

  // =====================================
  // line storage
  // =====================================

  always_ff @(posedge clk) begin
    if (fifo_ctrl_i.push) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= wdata_i;
    end
  end

  // extra msb tells full from empty
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr_q <= '0;
    end else if (fifo_ctrl_i.push) begin
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  // flush drops every stored line at once
  always_ff @(posedge clk) begin
    if (rst_n) begin
      rd_ptr_q <= '0;
    end else if (fifo_ctrl_i.flush) begin
      rd_ptr_q <= wr_ptr_q;
    end else if (fifo_ctrl_i.pop) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);

  // =====================================
  // instruction output
  // =====================================

  // empty FIFO forwards the response as it lands
  assign bypass = empty_o && r_fire_i && resp_live_i && resp_tag_match_i;

  assign src_line = empty_o ? wdata_i : mem[rd_ptr_q[PTR_W-1:0]];

  assign inst_valid_o = (!empty_o && head_hit_i) || bypass;
  assign inst_o       = src_line[word_idx_i * WORD_BITS +: WORD_BITS];

  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_n)
    fifo_ctrl_i.pop |-> !empty_o)
    else $error("pop issued on an empty FIFO");

endmodule

`default_nettype wire

// File: fetch_buffer_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer_top
  import fetch_pkg::*;
(
  input  wire         clk,
  input  wire         rst_n,
  input  fetch_addr_u pc_i,
  input  wire         jmp_flush_i,
  output ar_req_t     ar_o,
  input  wire         ar_ready_i,
  input  r_rsp_t      r_i,
  output logic        r_ready_o,
  output logic        inst_valid_o,
  output logic [31:0] inst_o
);

  fifo_ctrl_t  fifo_ctrl;
  line_tag_t   head_tag;
  logic [31:0] ar_addr;
  logic        ar_valid;
  logic        ar_fire;
  logic        r_fire;
  logic        head_hit;
  logic        pc_miss;
  logic        full;
  logic        empty;
  logic        resp_live;
  logic        resp_tag_match;

  assign ar_o    = '{valid: ar_valid, addr: ar_addr};
  assign ar_fire = ar_valid && ar_ready_i;
  assign r_fire  = r_i.valid && r_ready_o;

  // with an empty FIFO the head tag names the line in flight
  assign resp_tag_match = (head_tag == pc_i.f.tag);

  fetch_ctrl fetch_ctrl_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .jmp_flush_i (jmp_flush_i),
    .ar_ready_i  (ar_ready_i),
    .r_valid_i   (r_i.valid),
    .head_hit_i  (head_hit),
    .pc_miss_i   (pc_miss),
    .full_i      (full),
    .empty_i     (empty),
    .ar_valid_o  (ar_valid),
    .r_ready_o   (r_ready_o),
    .fifo_ctrl_o (fifo_ctrl),
    .resp_live_o (resp_live)
  );

  line_tag_tracker line_tag_tracker_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .pc_i        (pc_i),
    .ar_fire_i   (ar_fire),
    .fifo_ctrl_i (fifo_ctrl),
    .ar_addr_o   (ar_addr),
    .head_hit_o  (head_hit),
    .pc_miss_o   (pc_miss),
    .head_tag_o  (head_tag)
  );

  line_fifo line_fifo_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .fifo_ctrl_i      (fifo_ctrl),
    .wdata_i          (r_i.data),
    .resp_live_i      (resp_live),
    .r_fire_i         (r_fire),
    .resp_tag_match_i (resp_tag_match),
    .head_hit_i       (head_hit),
    .word_idx_i       (pc_i.f.word),
    .full_o           (full),
    .empty_o          (empty),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o)
  );

endmodule

`default_nettype wire

// File: tb_icache_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_buffer_defs.svh"

module tb_icache_model
  import fetch_pkg::*;
(
  input  wire     clk,
  input  wire     rst_n,
  input  ar_req_t ar_i,
  output logic    ar_ready_o,
  output r_rsp_t  r_o,
  input  wire     r_ready_i
);

  typedef enum logic [1:0] {M_ACCEPT, M_DELAY, M_RESP} phase_e;

  phase_e      phase = M_ACCEPT;
  int unsigned accept_wait = 0;
  int unsigned resp_wait = 0;
  logic [31:0] line_addr;
  logic        ar_hs = 1'b0;
  logic        r_hs = 1'b0;

  // word w of line A holds A + 4w scrambled by a fixed key
  function automatic logic [`FB_LINE_BITS-1:0] line_data(input logic [31:0] addr);
    logic [`FB_LINE_BITS-1:0] d;
    for (int w = 0; w < 4; w++) begin
      d[w*32 +: 32] = (addr + 32'(4 * w)) ^ 32'h5A5A_0000;
    end
    return d;
  endfunction

  // handshakes complete on the rising edge
  always @(posedge clk) begin
    ar_hs <= ar_i.valid && ar_ready_o;
    r_hs  <= r_o.valid && r_ready_i;
    if (ar_i.valid && ar_ready_o) begin
      line_addr <= ar_i.addr;
    end
  end

  initial begin
    ar_ready_o = 1'b0;
    r_o        = '0;
  end

  always @(negedge clk) begin
    if (rst_n) begin
      phase       = M_ACCEPT;
      accept_wait = 0;
      ar_ready_o  = 1'b0;
      r_o         = '0;
    end else begin
      case (phase)
        M_ACCEPT: begin
          if (ar_hs) begin
            ar_ready_o = 1'b0;
            resp_wait  = $urandom_range(5, 1);
            phase      = M_DELAY;
          end else if (accept_wait == 0) begin
            ar_ready_o = 1'b1;
          end else begin
            accept_wait = accept_wait - 1;
          end
        end
        M_DELAY: begin
          resp_wait = resp_wait - 1;
          if (resp_wait == 0) begin
            r_o.valid = 1'b1;
            r_o.data  = line_data(line_addr);
            phase     = M_RESP;
          end
        end
        default: begin
          if (r_hs) begin
            r_o         = '0;
            accept_wait = $urandom_range(3, 0);
            phase       = M_ACCEPT;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: tb_fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_buffer_defs.svh"

module tb_fetch_buffer
  import fetch_pkg::*;
();

  localparam int          EXP_WORDS    = 1 + 64 + 4 + 8 + 4;
  localparam int          LIMIT_CYCLES = 200 * EXP_WORDS + 500;
  localparam logic [31:0] KEY          = 32'h5A5A_0000;

  logic        clk = 1'b0;
  logic        rst_n;
  fetch_addr_u pc;
  logic        jmp_flush;
  ar_req_t     ar;
  logic        ar_ready;
  r_rsp_t      r;
  logic        r_ready;
  logic        inst_valid;
  logic [31:0] inst;
  logic        rst_d = 1'b0;
  logic        valid_seen = 1'b0;
  logic        ar_fire_seen = 1'b0;
  logic [31:0] exp_addr = `FB_RESET_PC;
  int          err_cnt = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          mark;

  always #2 clk = ~clk;

  fetch_buffer_top fetch_buffer_top_inst (
    .clk (clk), .rst_n (rst_n), .pc_i (pc), .jmp_flush_i (jmp_flush),
    .ar_o (ar), .ar_ready_i (ar_ready), .r_i (r), .r_ready_o (r_ready),
    .inst_valid_o (inst_valid), .inst_o (inst)
  );

  tb_icache_model icache_model_inst (
    .clk (clk), .rst_n (rst_n), .ar_i (ar), .ar_ready_o (ar_ready),
    .r_o (r), .r_ready_i (r_ready)
  );

  // expected next request line, built from the tag rules
  always @(posedge clk) begin
    rst_d        <= rst_n;
    valid_seen   <= inst_valid;
    ar_fire_seen <= ar.valid && ar_ready;
    if (rst_n) begin
      exp_addr <= `FB_RESET_PC;
    end else if (jmp_flush) begin
      exp_addr <= {pc.f.tag, 4'h0};
    end else if (ar.valid && ar_ready) begin
      exp_addr <= exp_addr + 32'd16;
    end
  end

  // ========================================
  // checks
  // ========================================

  a_reset_quiet: assert property (@(posedge clk) rst_d |-> !ar.valid && !r_ready && !inst_valid)
    else begin
      err_cnt = err_cnt + 1;
      $display("FAIL t=%0t reset outputs ar_o.valid/r_ready_o/inst_valid_o got %b%b%b exp 000",
               $time, $sampled(ar.valid), $sampled(r_ready), $sampled(inst_valid));
    end
  a_req_addr: assert property (@(posedge clk) disable iff (rst_n) ar.valid |-> ar.addr == exp_addr)
    else begin
      err_cnt = err_cnt + 1;
      $display("FAIL t=%0t ar_o.addr got %h exp %h", $time, $sampled(ar.addr), $sampled(exp_addr));
    end
  a_inst_data: assert property (@(posedge clk) disable iff (rst_n)
    inst_valid |-> inst == (pc.raw ^ KEY))
    else begin
      err_cnt = err_cnt + 1;
      $display("FAIL t=%0t inst_o got %h exp %h", $time, $sampled(inst), $sampled(pc.raw) ^ KEY);
    end
  // lines requested beyond the pc line stay within the FIFO depth
  a_window: assert property (@(posedge clk) disable iff (rst_n)
    !jmp_flush |-> 28'(exp_addr[31:4] - pc.f.tag) <= 28'(`FB_DEPTH))
    else begin
      err_cnt = err_cnt + 1;
      $display("too many lines requested ahead of the pc at t=%0t", $time);
    end
  a_ar_stable: assert property (@(posedge clk) disable iff (rst_n)
    (ar.valid && !ar_ready) |=> jmp_flush || (ar.valid && $stable(ar.addr)))
    else begin
      err_cnt = err_cnt + 1;
      $display("address request dropped or changed before ar_ready_i at t=%0t", $time);
    end
  a_one_outstanding: assert property (@(posedge clk) disable iff (rst_n) !(ar.valid && r_ready))
    else begin
      err_cnt = err_cnt + 1;
      $display("new address request while a read was outstanding at t=%0t", $time);
    end

  // ========================================
  // stimulus helpers
  // ========================================

  // pc steps only after the current word was delivered
  task automatic fetch_words(input int n);
    int got;
    got = 0;
    while (got < n) begin
      @(negedge clk);
      if (valid_seen) begin
        pc.raw = pc.raw + 32'd4;
        got = got + 1;
      end
    end
  endtask

  task automatic jump_to(input logic [31:0] target);
    pc.raw    = target;
    jmp_flush = 1'b1;
    @(negedge clk);
    jmp_flush = 1'b0;
  endtask

  function automatic logic [31:0] random_target();
    logic [31:0] base;
    base = $urandom() & 32'hFFFF_FFF0;
    return base | (32'($urandom_range(3, 0)) << 2);
  endfunction

  task automatic close_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      pass_cnt = pass_cnt + 1;
      $display("test %s: ok", name);
    end else begin
      fail_cnt = fail_cnt + 1;
      $display("test %s: %0d check(s) failed", name, err_cnt - errs_before);
    end
  endtask

  initial begin
    void'($urandom(68596));
    rst_n     = 1'b1;
    pc.raw    = `FB_RESET_PC;
    jmp_flush = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    mark = err_cnt;
    do @(negedge clk); while (!ar_fire_seen);
    close_test("reset and first request", mark);
    mark = err_cnt;
    fetch_words(64);
    close_test("sequential fetch", mark);
    mark = err_cnt;
    repeat (40) @(negedge clk);
    close_test("back-pressure", mark);
    // idle once nothing is in flight
    mark = err_cnt;
    do @(negedge clk); while (r_ready);
    jump_to(random_target());
    fetch_words(4);
    close_test("flush while idle", mark);
    mark = err_cnt;
    do @(negedge clk); while (!r_ready);
    jump_to(random_target());
    fetch_words(8);
    close_test("flush with read in flight", mark);
    mark = err_cnt;
    fetch_words(4);
    close_test("single outstanding request", mark);
    $display("tests ok %0d, tests failing %0d, failed checks %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, fetch stream stalled", LIMIT_CYCLES);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: fetch_buffer.f
+incdir+.
fetch_pkg.sv
fetch_ctrl.sv
line_tag_tracker.sv
line_fifo.sv
fetch_buffer_top.sv
tb_icache_model.sv
tb_fetch_buffer.sv
